// ==== bench/tb_poly_v_builder.sv ====
// Drives the top level through reset, message, noise, parallel and wrap cases; expects 100 ns clock
`default_nettype none

module tb_poly_v_builder;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int read_timeout = 8;

  logic                  clk;
  logic                  reset;
  logic                  msg_strobe;
  logic [7:0]            msg_byte;
  kyber_pkg::msg_idx_t   msg_index;
  logic                  noise_strobe;
  logic [7:0]            noise_byte;
  kyber_pkg::noise_idx_t noise_index;
  logic                  clear_strobe;
  logic                  rd_strobe;
  kyber_pkg::coeff_idx_t rd_index;
  logic                  rd_valid;
  kyber_pkg::coeff_t     rd_value;

  // Expected contents of the coefficient store
  int model [kyber_pkg::kyber_n];
  int value_errors;
  int other_errors;

  poly_v_builder u_poly_v_builder (
    .clk          (clk),
    .reset        (reset),
    .msg_strobe   (msg_strobe),
    .msg_byte     (msg_byte),
    .msg_index    (msg_index),
    .noise_strobe (noise_strobe),
    .noise_byte   (noise_byte),
    .noise_index  (noise_index),
    .clear_strobe (clear_strobe),
    .rd_strobe    (rd_strobe),
    .rd_index     (rd_index),
    .rd_valid     (rd_valid),
    .rd_value     (rd_value)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Centred binomial sample of one nibble, reduced into 0..q-1
  function automatic int cbd_of_nibble(input logic [3:0] nib);
    int pos;
    int neg;
    pos = int'(nib[0]) + int'(nib[1]);
    neg = int'(nib[2]) + int'(nib[3]);
    return (pos - neg + kyber_pkg::kyber_q) % kyber_pkg::kyber_q;
  endfunction

  function automatic void add_to_model(input int idx, input int val);
    model[idx] = (model[idx] + val) % kyber_pkg::kyber_q;
  endfunction

  function automatic void add_msg_to_model(input int idx, input logic [7:0] b);
    for (int j = 0; j < kyber_pkg::msg_bits; j++) begin
      add_to_model(idx * kyber_pkg::msg_bits + j, b[j] ? kyber_pkg::msg_half : 0);
    end
  endfunction

  function automatic void add_noise_to_model(input int idx, input logic [7:0] b);
    add_to_model(2 * idx, cbd_of_nibble(b[3:0]));
    add_to_model(2 * idx + 1, cbd_of_nibble(b[7:4]));
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic clear_store();
    @(posedge clk);
    clear_strobe <= 1'b1;
    @(posedge clk);
    clear_strobe <= 1'b0;
    for (int i = 0; i < kyber_pkg::kyber_n; i++) begin
      model[i] = 0;
    end
  endtask

  // Holds the byte for the full 8-cycle spacing
  task automatic send_msg(input int idx, input logic [7:0] b);
    @(posedge clk);
    msg_strobe <= 1'b1;
    msg_byte   <= b;
    msg_index  <= 5'(idx);
    @(posedge clk);
    msg_strobe <= 1'b0;
    add_msg_to_model(idx, b);
    idle_cycles(kyber_pkg::msg_bits - 2);
  endtask

  task automatic send_noise(input int idx, input logic [7:0] b);
    @(posedge clk);
    noise_strobe <= 1'b1;
    noise_byte   <= b;
    noise_index  <= 7'(idx);
    @(posedge clk);
    noise_strobe <= 1'b0;
    add_noise_to_model(idx, b);
  endtask

  task automatic read_check(input int idx);
    int wait_cnt;
    int exp_val;
    exp_val = model[idx];
    @(posedge clk);
    rd_strobe <= 1'b1;
    rd_index  <= 8'(idx);
    @(posedge clk);
    rd_strobe <= 1'b0;
    wait_cnt = 0;
    @(negedge clk);
    while (!rd_valid && wait_cnt < read_timeout) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!rd_valid) begin
      $display("Timed out waiting for rd_valid after reading index %0d", idx);
      other_errors++;
    end else begin
      assert (wait_cnt == 0) else begin
        $display("rd_valid came %0d cycles late for index %0d", wait_cnt, idx);
        other_errors++;
      end
      assert (rd_value === 12'(exp_val)) else begin
        $display("[FAIL] rd_value at index 0x%02h: expected 0x%03h, got 0x%03h",
                 idx, exp_val, rd_value);
        value_errors++;
      end
    end
  endtask

  task automatic check_all();
    for (int i = 0; i < kyber_pkg::kyber_n; i++) begin
      read_check(i);
    end
  endtask

  initial begin
    logic [7:0] b;
    reset        = 1'b1;
    msg_strobe   = 1'b0;
    msg_byte     = '0;
    msg_index    = '0;
    noise_strobe = 1'b0;
    noise_byte   = '0;
    noise_index  = '0;
    clear_strobe = 1'b0;
    rd_strobe    = 1'b0;
    rd_index     = '0;
    value_errors = 0;
    other_errors = 0;
    for (int i = 0; i < kyber_pkg::kyber_n; i++) begin
      model[i] = 0;
    end
    void'($urandom(32'he28d_2311));

    idle_cycles(16);
    reset <= 1'b0;

    // Store and read port come up empty
    @(negedge clk);
    assert (rd_valid === 1'b0) else begin
      $display("[FAIL] rd_valid after reset: expected 0x0, got 0x%0h", rd_valid);
      value_errors++;
    end
    read_check(0);
    read_check(1);
    read_check(128);
    read_check(255);

    // Message bytes alone
    for (int i = 0; i < 32; i++) begin
      send_msg(i, 8'($urandom));
    end
    idle_cycles(kyber_pkg::msg_bits + 2);
    check_all();

    // Noise bytes alone
    clear_store();
    for (int i = 0; i < 128; i++) begin
      send_noise(i, 8'($urandom));
    end
    idle_cycles(4);
    check_all();

    // Noise index 4i+t lines up with message bits 2t and 2t+1 of byte i
    clear_store();
    for (int i = 0; i < 32; i++) begin
      for (int t = 0; t < 4; t++) begin
        @(posedge clk);
        b = 8'($urandom);
        noise_strobe <= 1'b1;
        noise_byte   <= b;
        noise_index  <= 7'(4 * i + t);
        add_noise_to_model(4 * i + t, b);
        if (t == 0) begin
          b = 8'($urandom);
          msg_strobe <= 1'b1;
          msg_byte   <= b;
          msg_index  <= 5'(i);
          add_msg_to_model(i, b);
        end
        @(posedge clk);
        noise_strobe <= 1'b0;
        msg_strobe   <= 1'b0;
      end
    end
    idle_cycles(kyber_pkg::msg_bits + 2);
    check_all();

    // Two full bytes at one index wrap past q
    clear_store();
    send_msg(5, 8'hff);
    send_msg(5, 8'hff);
    idle_cycles(kyber_pkg::msg_bits + 2);
    for (int j = 40; j < 48; j++) begin
      read_check(j);
    end
    clear_store();
    for (int j = 40; j < 48; j++) begin
      read_check(j);
    end

    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/cbd_sampler.sv ====
// CBD with eta = 2 only, one byte gives two samples; strobes while busy are dropped
`default_nettype none

module cbd_sampler (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   noise_strobe,
  input  logic [7:0]             noise_byte,
  input  kyber_pkg::noise_idx_t  noise_index,
  output logic                   n_add,
  output kyber_pkg::coeff_idx_t  n_idx,
  output kyber_pkg::coeff_t      n_val
);

  logic                  busy;
  logic                  phase;
  logic [7:0]            byte_reg;
  kyber_pkg::noise_idx_t base_idx;
  logic                  accept;
  logic [3:0]            nibble;
  logic [1:0]            pos_sum;
  logic [1:0]            neg_sum;
  logic [1:0]            diff;

  // High nibble cycle frees the sampler for a new byte
  assign accept = noise_strobe && (!busy || phase);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy  <= 1'b0;
      phase <= 1'b0;
    end else if (accept) begin
      busy  <= 1'b1;
      phase <= 1'b0;
    end else if (busy) begin
      if (phase) begin
        busy  <= 1'b0;
        phase <= 1'b0;
      end else begin
        phase <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      byte_reg <= noise_byte;
      base_idx <= noise_index;
    end
  end

  // Sample is (b0 + b1) - (b2 + b3), range -2..2
  always_comb begin
    nibble  = phase ? byte_reg[7:4] : byte_reg[3:0];
    pos_sum = {1'b0, nibble[0]} + {1'b0, nibble[1]};
    neg_sum = {1'b0, nibble[2]} + {1'b0, nibble[3]};
    if (pos_sum >= neg_sum) begin
      diff  = pos_sum - neg_sum;
      n_val = {{(kyber_pkg::coeff_w - 2){1'b0}}, diff};
    end else begin
      // Negative sample wraps to q - |x|
      diff  = neg_sum - pos_sum;
      n_val = kyber_pkg::coeff_t'(kyber_pkg::kyber_q)
            - {{(kyber_pkg::coeff_w - 2){1'b0}}, diff};
    end
  end

  assign n_add = busy;
  assign n_idx = {base_idx, phase};

endmodule

`default_nettype wire

// ==== logic/coeff_accumulator.sv ====
// Inputs must already be below q; clear takes priority over adds and reads see pre-update values
`default_nettype none

module coeff_accumulator (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clear_strobe,
  input  logic                   m_add,
  input  kyber_pkg::coeff_idx_t  m_idx,
  input  kyber_pkg::coeff_t      m_val,
  input  logic                   n_add,
  input  kyber_pkg::coeff_idx_t  n_idx,
  input  kyber_pkg::coeff_t      n_val,
  input  logic                   rd_strobe,
  input  kyber_pkg::coeff_idx_t  rd_index,
  output logic                   rd_valid,
  output kyber_pkg::coeff_t      rd_value
);

  kyber_pkg::coeff_t coeff_mem [kyber_pkg::kyber_n];

  logic              collide;
  kyber_pkg::coeff_t m_extra;
  logic [13:0]       m_sum;
  logic [13:0]       n_sum;
  kyber_pkg::coeff_t m_new;
  kyber_pkg::coeff_t n_new;

  // Three terms stay below 3q, so two subtractions suffice
  function automatic kyber_pkg::coeff_t mod_q(input logic [13:0] sum);
    logic [13:0] r;
    r = sum;
    if (r >= 14'(kyber_pkg::kyber_q)) begin
      r = r - 14'(kyber_pkg::kyber_q);
    end
    if (r >= 14'(kyber_pkg::kyber_q)) begin
      r = r - 14'(kyber_pkg::kyber_q);
    end
    return r[kyber_pkg::coeff_w-1:0];
  endfunction

  // Both lanes on one index fold into the message lane write
  assign collide = m_add && n_add && (m_idx == n_idx);
  assign m_extra = collide ? n_val : '0;

  always_comb begin
    m_sum = {2'b00, coeff_mem[m_idx]} + {2'b00, m_val} + {2'b00, m_extra};
    n_sum = {2'b00, coeff_mem[n_idx]} + {2'b00, n_val};
    m_new = mod_q(m_sum);
    n_new = mod_q(n_sum);
  end

  // Store is zero after reset, clear beats any add
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < kyber_pkg::kyber_n; i++) begin
        coeff_mem[i] <= '0;
      end
    end else if (clear_strobe) begin
      for (int i = 0; i < kyber_pkg::kyber_n; i++) begin
        coeff_mem[i] <= '0;
      end
    end else begin
      if (m_add) begin
        coeff_mem[m_idx] <= m_new;
      end
      if (n_add && !collide) begin
        coeff_mem[n_idx] <= n_new;
      end
    end
  end

  // Read port, one cycle latency
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_strobe;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_strobe) begin
      rd_value <= coeff_mem[rd_index];
    end
  end

endmodule

`default_nettype wire

// ==== logic/kyber_pkg.sv ====
// Fixed to q = 3329 and n = 256; index types assume exactly 32 message bytes and 128 noise bytes
`default_nettype none

package kyber_pkg;

  // Ring parameters
  localparam int kyber_q = 3329;
  localparam int kyber_n = 256;

  // Decompress1 of a set bit, round(q/2)
  localparam int msg_half = 1665;

  // Coefficient width, enough for 0..q-1
  localparam int coeff_w = 12;

  // One message byte feeds this many coefficients
  localparam int msg_bits = 8;

  // Coefficient in canonical range 0..q-1
  typedef logic [coeff_w-1:0] coeff_t;

  // Index into the 256-entry polynomial
  typedef logic [7:0] coeff_idx_t;

  // Message byte number, 32 bytes of 8 bits cover n
  typedef logic [4:0] msg_idx_t;

  // Noise byte number, two samples per byte
  typedef logic [6:0] noise_idx_t;

endpackage

`default_nettype wire

// ==== logic/msg_decompress.sv ====
// Strobes arriving while bits are still pending are dropped; the host must space them 8 cycles apart
`default_nettype none

module msg_decompress (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   msg_strobe,
  input  logic [7:0]             msg_byte,
  input  kyber_pkg::msg_idx_t    msg_index,
  output logic                   m_add,
  output kyber_pkg::coeff_idx_t  m_idx,
  output kyber_pkg::coeff_t      m_val
);

  logic                busy;
  logic [2:0]          bit_cnt;
  logic [7:0]          shift_reg;
  kyber_pkg::msg_idx_t base_idx;
  logic                last_bit;
  logic                accept;

  // Eighth output goes out this cycle
  assign last_bit = (bit_cnt == 3'(kyber_pkg::msg_bits - 1));

  // Free again once the final bit is on the lane
  assign accept = msg_strobe && (!busy || last_bit);

  // Control state
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
    end else if (accept) begin
      busy    <= 1'b1;
      bit_cnt <= '0;
    end else if (busy) begin
      bit_cnt <= bit_cnt + 3'd1;
      if (last_bit) begin
        busy <= 1'b0;
      end
    end
  end

  // Byte and base index, payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_reg <= msg_byte;
      base_idx  <= msg_index;
    end else if (busy) begin
      shift_reg <= {1'b0, shift_reg[7:1]};
    end
  end

  // Bit j of byte i lands on coefficient 8i+j
  assign m_add = busy;
  assign m_idx = {base_idx, bit_cnt};
  assign m_val = shift_reg[0] ? kyber_pkg::coeff_t'(kyber_pkg::msg_half) : '0;

endmodule

`default_nettype wire

// ==== logic/poly_v_builder.sv ====
// No back-pressure: host spaces message strobes 8 cycles and noise strobes 2 cycles apart
`default_nettype none

module poly_v_builder (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   msg_strobe,
  input  logic [7:0]             msg_byte,
  input  kyber_pkg::msg_idx_t    msg_index,
  input  logic                   noise_strobe,
  input  logic [7:0]             noise_byte,
  input  kyber_pkg::noise_idx_t  noise_index,
  input  logic                   clear_strobe,
  input  logic                   rd_strobe,
  input  kyber_pkg::coeff_idx_t  rd_index,
  output logic                   rd_valid,
  output kyber_pkg::coeff_t      rd_value
);

  // Message lane
  logic                  m_add;
  kyber_pkg::coeff_idx_t m_idx;
  kyber_pkg::coeff_t     m_val;

  // Noise lane
  logic                  n_add;
  kyber_pkg::coeff_idx_t n_idx;
  kyber_pkg::coeff_t     n_val;

  msg_decompress u_msg_decompress (
    .clk        (clk),
    .reset      (reset),
    .msg_strobe (msg_strobe),
    .msg_byte   (msg_byte),
    .msg_index  (msg_index),
    .m_add      (m_add),
    .m_idx      (m_idx),
    .m_val      (m_val)
  );

  cbd_sampler u_cbd_sampler (
    .clk          (clk),
    .reset        (reset),
    .noise_strobe (noise_strobe),
    .noise_byte   (noise_byte),
    .noise_index  (noise_index),
    .n_add        (n_add),
    .n_idx        (n_idx),
    .n_val        (n_val)
  );

  // Holds v = Decompress1(m) + e2 mod q
  coeff_accumulator u_coeff_accumulator (
    .clk          (clk),
    .reset        (reset),
    .clear_strobe (clear_strobe),
    .m_add        (m_add),
    .m_idx        (m_idx),
    .m_val        (m_val),
    .n_add        (n_add),
    .n_idx        (n_idx),
    .n_val        (n_val),
    .rd_strobe    (rd_strobe),
    .rd_index     (rd_index),
    .rd_valid     (rd_valid),
    .rd_value     (rd_value)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module tb_poly_v_builder \
  -f src.f \
  -o sim_tb_poly_v_builder
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/sim_tb_poly_v_builder)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test passed" <<< "$sim_output"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// ==== src.f ====
logic/kyber_pkg.sv
logic/msg_decompress.sv
logic/cbd_sampler.sv
logic/coeff_accumulator.sv
logic/poly_v_builder.sv
bench/tb_poly_v_builder.sv
